// ==== Makefile ====
SIM      = verilator --binary
FLAGS    = --assert -j 0
TOP      = tb_noc_axi_bridge
FILELIST = build.f

SRCS     = $(shell grep -v '^+' $(FILELIST)) bridge_consts.svh
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Simulation failed" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== axi_lite_master.sv ====
`timescale 1ns/100ps
`include "bridge_consts.svh"

module axi_lite_master import bridge_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    txn_if.sink                      txn,
    cpl_if.source                    cpl,
    output logic                     axi_awvalid,
    input  logic                     axi_awready,
    output axi_addr_t                axi_awaddr,
    output logic                     axi_wvalid,
    input  logic                     axi_wready,
    output axi_data_t                axi_wdata,
    output logic [`AXI_DATA_W/8-1:0] axi_wstrb,
    input  logic                     axi_bvalid,
    output logic                     axi_bready,
    input  axi_resp_t                axi_bresp,
    output logic                     axi_arvalid,
    input  logic                     axi_arready,
    output axi_addr_t                axi_araddr,
    input  logic                     axi_rvalid,
    output logic                     axi_rready,
    input  axi_data_t                axi_rdata,
    input  axi_resp_t                axi_rresp
);

    axi_state_t state;
    axi_state_t state_next;

    // aw and w may complete in either order
    logic      aw_done;
    logic      w_done;
    logic      aw_hs;
    logic      w_hs;

    // held copy of the transaction
    logic      is_write;
    msg_type_t ack_type;
    axi_addr_t addr;
    axi_data_t wdata;
    axi_data_t rdata;
    mshr_t     mshr;
    chipid_t   chipid;
    coord_t    src_x;
    coord_t    src_y;

    assign aw_hs = axi_awvalid && axi_awready;
    assign w_hs  = axi_wvalid && axi_wready;

    always_comb begin
        state_next = state;
        case (state)
            ax_idle: begin
                if (txn.valid && txn.ready) begin
                    state_next = txn.is_write ? ax_write : ax_read_addr;
                end
            end
            ax_write: begin
                if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                    state_next = ax_write_resp;
                end
            end
            ax_write_resp: begin
                // error response reissues address and data
                if (axi_bvalid) begin
                    state_next = (axi_bresp == `AXI_RESP_OKAY) ? ax_complete : ax_write;
                end
            end
            ax_read_addr: begin
                if (axi_arready) begin
                    state_next = ax_read_data;
                end
            end
            ax_read_data: begin
                // error response goes back for another ar
                if (axi_rvalid) begin
                    state_next = (axi_rresp == `AXI_RESP_OKAY) ? ax_complete : ax_read_addr;
                end
            end
            ax_complete: begin
                if (cpl.ready) begin
                    state_next = ax_idle;
                end
            end
            default: begin
                state_next = ax_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ax_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= state_next;
            // flags cleared on leaving write so a retry starts fresh
            if (state == ax_write) begin
                aw_done <= aw_done || aw_hs;
                w_done  <= w_done || w_hs;
            end else begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (txn.valid && txn.ready) begin
            is_write <= txn.is_write;
            ack_type <= txn.ack_type;
            addr     <= txn.addr;
            wdata    <= txn.wdata;
            mshr     <= txn.mshr;
            chipid   <= txn.chipid;
            src_x    <= txn.src_x;
            src_y    <= txn.src_y;
        end
        if (axi_rvalid && axi_rready) begin
            rdata <= axi_rdata;
        end
    end

    // one transaction at a time
    assign txn.ready = (state == ax_idle);

    // write channels
    assign axi_awvalid = (state == ax_write) && !aw_done;
    assign axi_wvalid  = (state == ax_write) && !w_done;
    assign axi_awaddr  = addr;
    assign axi_wdata   = wdata;
    // full word writes only
    assign axi_wstrb   = '1;
    assign axi_bready  = (state == ax_write_resp);

    // read channels
    assign axi_arvalid = (state == ax_read_addr);
    assign axi_araddr  = addr;
    assign axi_rready  = (state == ax_read_data);

    assign cpl.valid    = (state == ax_complete);
    assign cpl.is_write = is_write;
    assign cpl.ack_type = ack_type;
    assign cpl.rdata    = rdata;
    assign cpl.mshr     = mshr;
    assign cpl.chipid   = chipid;
    assign cpl.src_x    = src_x;
    assign cpl.src_y    = src_y;

endmodule

// ==== bridge_consts.svh ====
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// noc flit width
`define NOC_FLIT_W              64

// header flit fields
`define MSG_TYPE                21:14
`define MSG_TYPE_W              8
// flit count after the header
`define MSG_LENGTH              29:22
`define MSG_LENGTH_W            8
`define MSG_MSHRID              13:6
`define MSG_MSHRID_W            8

// address flit, low byte of the physical address
`define MSG_ADDR                23:16

// source routing flit
`define MSG_SRC_CHIPID          63:50
`define MSG_SRC_CHIPID_W        14
`define MSG_SRC_X               49:42
`define MSG_SRC_Y               41:34
`define MSG_SRC_XY_W            8

// request types
`define MSG_TYPE_LOAD_REQ       8'd31
`define MSG_TYPE_STORE_REQ      8'd2
`define MSG_TYPE_NC_LOAD_REQ    8'd14
`define MSG_TYPE_NC_STORE_REQ   8'd15
`define MSG_TYPE_LOAD_MEM       8'd19
`define MSG_TYPE_STORE_MEM      8'd20

// response types
`define MSG_TYPE_LOAD_MEM_ACK       8'd24
`define MSG_TYPE_STORE_MEM_ACK      8'd25
`define MSG_TYPE_NC_LOAD_MEM_ACK    8'd26
`define MSG_TYPE_NC_STORE_MEM_ACK   8'd27

// axi4-lite side
`define AXI_ADDR_W              8
`define AXI_DATA_W              32
`define AXI_RESP_W              2
`define AXI_RESP_OKAY           2'b00
`define AXI_RESP_SLVERR         2'b10

`endif

// ==== bridge_if.sv ====
`timescale 1ns/100ps

// parsed request, parser to axi master
interface txn_if import bridge_pkg::*; ();
    logic      valid;
    logic      ready;
    // store when set, load otherwise
    logic      is_write;
    // ack code picked from the request type
    msg_type_t ack_type;
    axi_addr_t addr;
    axi_data_t wdata;
    mshr_t     mshr;
    // requester route, echoed in the response
    chipid_t   chipid;
    coord_t    src_x;
    coord_t    src_y;

    modport source (
        output valid, is_write, ack_type, addr, wdata, mshr, chipid, src_x, src_y,
        input  ready
    );

    modport sink (
        input  valid, is_write, ack_type, addr, wdata, mshr, chipid, src_x, src_y,
        output ready
    );
endinterface

// finished axi transaction, master to response builder
interface cpl_if import bridge_pkg::*; ();
    logic      valid;
    logic      ready;
    logic      is_write;
    msg_type_t ack_type;
    // read word, unused for stores
    axi_data_t rdata;
    mshr_t     mshr;
    chipid_t   chipid;
    coord_t    src_x;
    coord_t    src_y;

    modport source (
        output valid, is_write, ack_type, rdata, mshr, chipid, src_x, src_y,
        input  ready
    );

    modport sink (
        input  valid, is_write, ack_type, rdata, mshr, chipid, src_x, src_y,
        output ready
    );
endinterface

// ==== bridge_pkg.sv ====
`include "bridge_consts.svh"

package bridge_pkg;

    // one network flit
    typedef logic [`NOC_FLIT_W-1:0]        noc_flit_t;

    // header fields
    typedef logic [`MSG_TYPE_W-1:0]        msg_type_t;
    typedef logic [`MSG_LENGTH_W-1:0]      msg_len_t;
    typedef logic [`MSG_MSHRID_W-1:0]      mshr_t;

    // return route of the requester
    typedef logic [`MSG_SRC_CHIPID_W-1:0]  chipid_t;
    typedef logic [`MSG_SRC_XY_W-1:0]      coord_t;

    // axi4-lite payload
    typedef logic [`AXI_ADDR_W-1:0]        axi_addr_t;
    typedef logic [`AXI_DATA_W-1:0]        axi_data_t;
    typedef logic [`AXI_RESP_W-1:0]        axi_resp_t;

    // request parser
    typedef enum logic [2:0] {
        ps_idle,
        ps_header2,
        ps_header3,
        ps_data,
        ps_discard,
        ps_handoff
    } parser_state_t;

    // axi master, one transaction at a time
    typedef enum logic [2:0] {
        ax_idle,
        ax_write,
        ax_write_resp,
        ax_read_addr,
        ax_read_data,
        ax_complete
    } axi_state_t;

    // response serializer
    typedef enum logic [1:0] {
        rs_idle,
        rs_header,
        rs_data
    } resp_state_t;

endpackage

// ==== build.f ====
+incdir+.
bridge_pkg.sv
bridge_if.sv
noc_req_parser.sv
axi_lite_master.sv
noc_resp_builder.sv
noc_axi_bridge.sv
noc_axi_bridge_chk.sv
tb_noc_axi_bridge.sv

// ==== noc_axi_bridge.sv ====
`timescale 1ns/100ps
`include "bridge_consts.svh"

module noc_axi_bridge import bridge_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    // requests from the network
    input  logic                     noc_in_val,
    input  noc_flit_t                noc_in_data,
    output logic                     noc_in_rdy,
    // responses to the network
    output logic                     noc_out_val,
    output noc_flit_t                noc_out_data,
    input  logic                     noc_out_rdy,
    // axi4-lite master
    output logic                     axi_awvalid,
    input  logic                     axi_awready,
    output axi_addr_t                axi_awaddr,
    output logic                     axi_wvalid,
    input  logic                     axi_wready,
    output axi_data_t                axi_wdata,
    output logic [`AXI_DATA_W/8-1:0] axi_wstrb,
    input  logic                     axi_bvalid,
    output logic                     axi_bready,
    input  axi_resp_t                axi_bresp,
    output logic                     axi_arvalid,
    input  logic                     axi_arready,
    output axi_addr_t                axi_araddr,
    input  logic                     axi_rvalid,
    output logic                     axi_rready,
    input  axi_data_t                axi_rdata,
    input  axi_resp_t                axi_rresp
);

    // parser to master, master to builder
    txn_if txn ();
    cpl_if cpl ();

    noc_req_parser u_parser (
        .clk         (clk),
        .rst         (rst),
        .noc_in_val  (noc_in_val),
        .noc_in_data (noc_in_data),
        .noc_in_rdy  (noc_in_rdy),
        .txn         (txn.source)
    );

    axi_lite_master u_axi (
        .clk         (clk),
        .rst         (rst),
        .txn         (txn.sink),
        .cpl         (cpl.source),
        .axi_awvalid (axi_awvalid),
        .axi_awready (axi_awready),
        .axi_awaddr  (axi_awaddr),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_bvalid  (axi_bvalid),
        .axi_bready  (axi_bready),
        .axi_bresp   (axi_bresp),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_araddr  (axi_araddr),
        .axi_rvalid  (axi_rvalid),
        .axi_rready  (axi_rready),
        .axi_rdata   (axi_rdata),
        .axi_rresp   (axi_rresp)
    );

    noc_resp_builder u_resp (
        .clk          (clk),
        .rst          (rst),
        .cpl          (cpl.sink),
        .noc_out_val  (noc_out_val),
        .noc_out_data (noc_out_data),
        .noc_out_rdy  (noc_out_rdy)
    );

endmodule

// ==== noc_axi_bridge_chk.sv ====
`timescale 1ns/100ps
`include "bridge_consts.svh"

module noc_axi_bridge_chk import bridge_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      noc_in_rdy,
    input logic      noc_out_val,
    input noc_flit_t noc_out_data,
    input logic      noc_out_rdy,
    input logic      axi_awvalid,
    input logic      axi_awready,
    input axi_addr_t axi_awaddr,
    input logic      axi_wvalid,
    input logic      axi_wready,
    input axi_data_t axi_wdata,
    input logic      axi_bvalid,
    input logic      axi_bready,
    input axi_resp_t axi_bresp,
    input logic      axi_arvalid,
    input logic      axi_arready,
    input axi_addr_t axi_araddr,
    input logic      axi_rvalid,
    input logic      axi_rready,
    input axi_resp_t axi_rresp
);

    // okay axi completions against response headers started
    int unsigned done_cnt;
    int unsigned hdr_cnt;
    logic        val_q;
    logic        val_rise;

    assign val_rise = noc_out_val && !val_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_cnt <= 0;
            hdr_cnt  <= 0;
            val_q    <= 1'b0;
        end else begin
            val_q <= noc_out_val;
            if ((axi_bvalid && axi_bready && axi_bresp == `AXI_RESP_OKAY) ||
                (axi_rvalid && axi_rready && axi_rresp == `AXI_RESP_OKAY)) begin
                done_cnt <= done_cnt + 1;
            end
            if (val_rise) begin
                hdr_cnt <= hdr_cnt + 1;
            end
        end
    end

    // quiet outputs in reset and one cycle after
    a_reset: assert property (@(posedge clk) (rst || $past(rst)) |-> !(noc_in_rdy ||
        noc_out_val || axi_awvalid || axi_wvalid || axi_arvalid || axi_bready || axi_rready))
        else $error("outputs active around reset");

    a_resp_after_axi: assert property (@(posedge clk) disable iff (rst)
        val_rise |-> done_cnt > hdr_cnt)
        else $error("response started without a finished axi transaction");

    // error responses are retried at once
    a_write_retry: assert property (@(posedge clk) disable iff (rst)
        (axi_bvalid && axi_bready && axi_bresp != `AXI_RESP_OKAY) |=> axi_awvalid)
        else $error("no aw reissue after write error");
    a_read_retry: assert property (@(posedge clk) disable iff (rst)
        (axi_rvalid && axi_rready && axi_rresp != `AXI_RESP_OKAY) |=> axi_arvalid)
        else $error("no ar reissue after read error");

    // hold under back-pressure
    a_noc_hold: assert property (@(posedge clk) disable iff (rst)
        (noc_out_val && !noc_out_rdy) |=> noc_out_val && $stable(noc_out_data))
        else $error("response flit changed while stalled");
    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        (axi_awvalid && !axi_awready) |=> axi_awvalid && $stable(axi_awaddr))
        else $error("aw changed while stalled");
    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        (axi_wvalid && !axi_wready) |=> axi_wvalid && $stable(axi_wdata))
        else $error("w changed while stalled");
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        (axi_arvalid && !axi_arready) |=> axi_arvalid && $stable(axi_araddr))
        else $error("ar changed while stalled");

endmodule

bind noc_axi_bridge noc_axi_bridge_chk u_chk (.*);

// ==== noc_req_parser.sv ====
`timescale 1ns/100ps
`include "bridge_consts.svh"

module noc_req_parser import bridge_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      noc_in_val,
    input  noc_flit_t noc_in_data,
    output logic      noc_in_rdy,
    txn_if.source     txn
);

    parser_state_t state;
    parser_state_t state_next;

    // flits taken since the header flit
    msg_len_t  cnt;
    msg_len_t  msg_len;
    logic      is_write;
    msg_type_t ack_type;
    mshr_t     mshr;
    axi_addr_t addr;
    axi_data_t wdata;
    chipid_t   chipid;
    coord_t    src_x;
    coord_t    src_y;

    logic      go;
    logic      last;
    msg_type_t in_type;
    logic      in_load;
    logic      in_store;
    msg_type_t in_ack;

    assign go   = noc_in_val && noc_in_rdy;
    // final flit of the packet per its length field
    assign last = (cnt == msg_len - 8'd1);

    // type decode straight off the header flit
    assign in_type = noc_in_data[`MSG_TYPE];

    always_comb begin
        in_load  = 1'b0;
        in_store = 1'b0;
        in_ack   = '0;
        case (in_type)
            `MSG_TYPE_LOAD_REQ, `MSG_TYPE_LOAD_MEM: begin
                in_load = 1'b1;
                in_ack  = `MSG_TYPE_LOAD_MEM_ACK;
            end
            `MSG_TYPE_NC_LOAD_REQ: begin
                in_load = 1'b1;
                in_ack  = `MSG_TYPE_NC_LOAD_MEM_ACK;
            end
            `MSG_TYPE_STORE_REQ, `MSG_TYPE_STORE_MEM: begin
                in_store = 1'b1;
                in_ack   = `MSG_TYPE_STORE_MEM_ACK;
            end
            `MSG_TYPE_NC_STORE_REQ: begin
                in_store = 1'b1;
                in_ack   = `MSG_TYPE_NC_STORE_MEM_ACK;
            end
            // anything else gets dropped
            default: ;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            ps_idle: begin
                if (go) begin
                    if (in_load || in_store) begin
                        state_next = ps_header2;
                    end else if (noc_in_data[`MSG_LENGTH] != '0) begin
                        state_next = ps_discard;
                    end
                end
            end
            ps_header2: begin
                if (go) begin
                    state_next = ps_header3;
                end
            end
            ps_header3: begin
                // loads end here, stores go on to their data
                if (go) begin
                    state_next = (!is_write || last) ? ps_handoff : ps_data;
                end
            end
            ps_data: begin
                if (go && last) begin
                    state_next = ps_handoff;
                end
            end
            ps_discard: begin
                if (go && last) begin
                    state_next = ps_idle;
                end
            end
            ps_handoff: begin
                if (txn.valid && txn.ready) begin
                    state_next = ps_idle;
                end
            end
            default: begin
                state_next = ps_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ps_idle;
            cnt        <= '0;
            noc_in_rdy <= 1'b0;
        end else begin
            state      <= state_next;
            // stall the network while a request waits for the master
            noc_in_rdy <= (state_next != ps_handoff);
            if (go) begin
                cnt <= (state == ps_idle) ? '0 : cnt + 8'd1;
            end
        end
    end

    // request fields
    always_ff @(posedge clk) begin
        if (go) begin
            case (state)
                ps_idle: begin
                    msg_len  <= noc_in_data[`MSG_LENGTH];
                    mshr     <= noc_in_data[`MSG_MSHRID];
                    is_write <= in_store;
                    ack_type <= in_ack;
                end
                ps_header2: begin
                    addr <= noc_in_data[`MSG_ADDR];
                end
                ps_header3: begin
                    chipid <= noc_in_data[`MSG_SRC_CHIPID];
                    src_x  <= noc_in_data[`MSG_SRC_X];
                    src_y  <= noc_in_data[`MSG_SRC_Y];
                end
                ps_data: begin
                    // only the first data word is written, the rest drain
                    if (cnt == 8'd2) begin
                        wdata <= noc_in_data[`AXI_DATA_W-1:0];
                    end
                end
                default: ;
            endcase
        end
    end

    assign txn.valid    = (state == ps_handoff);
    assign txn.is_write = is_write;
    assign txn.ack_type = ack_type;
    assign txn.addr     = addr;
    assign txn.wdata    = wdata;
    assign txn.mshr     = mshr;
    assign txn.chipid   = chipid;
    assign txn.src_x    = src_x;
    assign txn.src_y    = src_y;

endmodule

// ==== noc_resp_builder.sv ====
`timescale 1ns/100ps
`include "bridge_consts.svh"

module noc_resp_builder import bridge_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    cpl_if.sink       cpl,
    output logic      noc_out_val,
    output noc_flit_t noc_out_data,
    input  logic      noc_out_rdy
);

    resp_state_t state;
    resp_state_t state_next;

    logic      is_write;
    msg_type_t ack_type;
    axi_data_t rdata;
    mshr_t     mshr;
    chipid_t   chipid;
    coord_t    src_x;
    coord_t    src_y;

    logic      go;
    msg_len_t  resp_len;
    noc_flit_t header;

    assign go = noc_out_val && noc_out_rdy;

    // store ack is bare, load ack carries one data flit
    assign resp_len = is_write ? 8'd0 : 8'd1;
    // route back to requester, flag bits zero
    assign header = {chipid, src_x, src_y, 4'h0, resp_len, ack_type, mshr, 6'h0};

    always_comb begin
        state_next = state;
        case (state)
            rs_idle: begin
                if (cpl.valid && cpl.ready) begin
                    state_next = rs_header;
                end
            end
            rs_header: begin
                if (go) begin
                    state_next = is_write ? rs_idle : rs_data;
                end
            end
            rs_data: begin
                if (go) begin
                    state_next = rs_idle;
                end
            end
            default: begin
                state_next = rs_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= rs_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (cpl.valid && cpl.ready) begin
            is_write <= cpl.is_write;
            ack_type <= cpl.ack_type;
            rdata    <= cpl.rdata;
            mshr     <= cpl.mshr;
            chipid   <= cpl.chipid;
            src_x    <= cpl.src_x;
            src_y    <= cpl.src_y;
        end
    end

    assign cpl.ready   = (state == rs_idle);
    assign noc_out_val = (state != rs_idle);

    // flit mux, held by the registered fields while stalled
    always_comb begin
        case (state)
            rs_header: noc_out_data = header;
            rs_data:   noc_out_data = {{(`NOC_FLIT_W-`AXI_DATA_W){1'b0}}, rdata};
            default:   noc_out_data = '0;
        endcase
    end

endmodule

// ==== tb_noc_axi_bridge.sv ====
`timescale 1ns/100ps
`include "bridge_consts.svh"

module tb_noc_axi_bridge import bridge_pkg::*; ();

    logic                     clk;
    logic                     rst;
    logic                     noc_in_val;
    noc_flit_t                noc_in_data;
    logic                     noc_in_rdy;
    logic                     noc_out_val;
    noc_flit_t                noc_out_data;
    logic                     noc_out_rdy = 1'b0;
    logic                     axi_awvalid;
    logic                     axi_awready = 1'b0;
    axi_addr_t                axi_awaddr;
    logic                     axi_wvalid;
    logic                     axi_wready = 1'b0;
    axi_data_t                axi_wdata;
    logic [`AXI_DATA_W/8-1:0] axi_wstrb;
    logic                     axi_bvalid = 1'b0;
    logic                     axi_bready;
    axi_resp_t                axi_bresp = `AXI_RESP_OKAY;
    logic                     axi_arvalid;
    logic                     axi_arready = 1'b0;
    axi_addr_t                axi_araddr;
    logic                     axi_rvalid = 1'b0;
    logic                     axi_rready;
    axi_data_t                axi_rdata = '0;
    axi_resp_t                axi_rresp = `AXI_RESP_OKAY;

    integer      seed = 95;
    int          cycles = 0;
    // slave memory and the scoreboard's own copy
    axi_data_t   mem [256];
    axi_data_t   ref_mem [256];
    noc_flit_t   exp_q [$];
    noc_flit_t   exp_flit;
    // slave model state
    logic        have_aw;
    logic        have_w;
    axi_addr_t   aw_a;
    axi_data_t   w_d;
    logic        b_pend;
    logic        r_pend;
    logic        err_w_used;
    logic        err_r_used;
    // response payloads, put on the bus at the next falling edge
    axi_resp_t   b_code;
    axi_resp_t   r_code;
    axi_data_t   r_word;
    logic [31:0] sr;

    noc_axi_bridge dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task stop_with_failure(input string why);
        $display("Simulation failed");
        $fatal(1, "%s", why);
    endtask

    // cycle budget for about 40 packets under random stalls
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4000) begin
            stop_with_failure("timeout, responses did not all arrive within 4000 cycles");
        end
    end

    // fill pattern over the whole address
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i]     = {8'hc3, i[7:0], ~i[7:0], i[7:0] ^ 8'h5a};
            ref_mem[i] = {8'hc3, i[7:0], ~i[7:0], i[7:0] ^ 8'h5a};
        end
    end

    // slave bookkeeping at the clock edge
    always @(posedge clk) begin
        if (rst) begin
            have_aw    = 1'b0;
            have_w     = 1'b0;
            b_pend     = 1'b0;
            r_pend     = 1'b0;
            err_w_used = 1'b0;
            err_r_used = 1'b0;
            b_code     = `AXI_RESP_OKAY;
            r_code     = `AXI_RESP_OKAY;
            r_word     = '0;
        end else begin
            if (axi_awvalid && axi_awready) begin
                have_aw = 1'b1;
                aw_a    = axi_awaddr;
            end
            if (axi_wvalid && axi_wready) begin
                have_w = 1'b1;
                w_d    = axi_wdata;
                // full word writes only
                assert (axi_wstrb == 4'hf) else begin
                    $display("Fail axi_wstrb expected f actual %h", axi_wstrb);
                    stop_with_failure("write strobe not all ones");
                end
            end
            if (axi_bvalid && axi_bready) b_pend = 1'b0;
            if (axi_rvalid && axi_rready) r_pend = 1'b0;
            if (have_aw && have_w && !b_pend) begin
                // one slverr on the first write to a5, no update then
                if (aw_a == 8'ha5 && !err_w_used) begin
                    err_w_used = 1'b1;
                    b_code     = `AXI_RESP_SLVERR;
                end else begin
                    mem[aw_a] = w_d;
                    b_code    = `AXI_RESP_OKAY;
                end
                b_pend  = 1'b1;
                have_aw = 1'b0;
                have_w  = 1'b0;
            end
            if (axi_arvalid && axi_arready) begin
                r_word = mem[axi_araddr];
                r_code = `AXI_RESP_OKAY;
                if (axi_araddr == 8'ha5 && !err_r_used) begin
                    err_r_used = 1'b1;
                    r_code     = `AXI_RESP_SLVERR;
                end
                r_pend = 1'b1;
            end
        end
    end

    // random readies, driven away from the sampling edge
    always @(negedge clk) begin
        sr          = $random(seed);
        axi_awready = !have_aw && sr[0];
        axi_wready  = !have_w && sr[1];
        axi_arready = !r_pend && sr[2];
        axi_bvalid  = b_pend;
        axi_bresp   = b_code;
        axi_rvalid  = r_pend;
        axi_rdata   = r_word;
        axi_rresp   = r_code;
        noc_out_rdy = sr[3] | sr[4];
    end

    // response monitor
    always @(posedge clk) begin
        if (!rst && noc_out_val && noc_out_rdy) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("a response flit came out with none expected");
            end else begin
                exp_flit = exp_q.pop_front();
                assert (noc_out_data == exp_flit) else begin
                    $display("Fail noc_out_data expected %h actual %h", exp_flit, noc_out_data);
                    stop_with_failure("response flit mismatch");
                end
            end
        end
    end

    function automatic noc_flit_t ack_header(chipid_t c, coord_t x, coord_t y,
                                             msg_len_t len, msg_type_t ack, mshr_t id);
        return {c, x, y, 4'h0, len, ack, id, 6'h0};
    endfunction

    // one flit, called on a falling edge
    task send_flit(input noc_flit_t f);
        noc_in_val  = 1'b1;
        noc_in_data = f;
        while (!noc_in_rdy) @(negedge clk);
        @(negedge clk);
        noc_in_val = 1'b0;
    endtask

    // header, address and route flits
    task send_head(input msg_type_t ty, input msg_len_t len, input mshr_t id,
                   input axi_addr_t a, input chipid_t c, input coord_t x, input coord_t y);
        noc_flit_t f;
        f = '0;
        f[`MSG_TYPE]   = ty;
        f[`MSG_LENGTH] = len;
        f[`MSG_MSHRID] = id;
        send_flit(f);
        f = '0;
        f[`MSG_ADDR] = a;
        send_flit(f);
        f = '0;
        f[`MSG_SRC_CHIPID] = c;
        f[`MSG_SRC_X]      = x;
        f[`MSG_SRC_Y]      = y;
        send_flit(f);
    endtask

    task store_word(input msg_type_t ty, input msg_type_t ack, input mshr_t id,
                    input axi_addr_t a, input axi_data_t d, input msg_len_t len);
        logic [31:0] r;
        logic [31:0] junk;
        r = $random(seed);
        ref_mem[a] = d;
        exp_q.push_back(ack_header(r[13:0], r[21:14], r[29:22], 8'd0, ack, id));
        send_head(ty, len, id, a, r[13:0], r[21:14], r[29:22]);
        junk = $random(seed);
        // upper half must be ignored
        send_flit({junk, d});
        for (int k = 3; k < len; k++) begin
            junk = $random(seed);
            send_flit({junk, ~junk});
        end
    endtask

    task load_word(input msg_type_t ty, input msg_type_t ack, input mshr_t id,
                   input axi_addr_t a);
        logic [31:0] r;
        r = $random(seed);
        exp_q.push_back(ack_header(r[13:0], r[21:14], r[29:22], 8'd1, ack, id));
        exp_q.push_back({32'h0, ref_mem[a]});
        send_head(ty, 8'd2, id, a, r[13:0], r[21:14], r[29:22]);
    endtask

    task drop_packet(input msg_type_t ty, input msg_len_t len);
        noc_flit_t f;
        logic [31:0] junk;
        f = '0;
        f[`MSG_TYPE]   = ty;
        f[`MSG_LENGTH] = len;
        send_flit(f);
        for (int k = 0; k < len; k++) begin
            junk = $random(seed);
            send_flit({~junk, junk});
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        rst         = 1'b1;
        noc_in_val  = 1'b0;
        noc_in_data = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // store then load, both ack flavors
        r = $random(seed);
        d = $random(seed);
        store_word(`MSG_TYPE_NC_STORE_REQ, `MSG_TYPE_NC_STORE_MEM_ACK, 8'h01, r[7:0], d, 8'd3);
        load_word(`MSG_TYPE_NC_LOAD_REQ, `MSG_TYPE_NC_LOAD_MEM_ACK, 8'h02, r[7:0]);
        d = $random(seed);
        store_word(`MSG_TYPE_STORE_REQ, `MSG_TYPE_STORE_MEM_ACK, 8'h03, 8'h40, d, 8'd3);
        load_word(`MSG_TYPE_LOAD_REQ, `MSG_TYPE_LOAD_MEM_ACK, 8'h04, 8'h40);
        d = $random(seed);
        store_word(`MSG_TYPE_STORE_MEM, `MSG_TYPE_STORE_MEM_ACK, 8'h05, 8'h41, d, 8'd5);
        load_word(`MSG_TYPE_LOAD_MEM, `MSG_TYPE_LOAD_MEM_ACK, 8'h06, 8'h41);

        // unsupported types are dropped
        drop_packet(8'd99, 8'd0);
        drop_packet(8'd7, 8'd3);
        load_word(`MSG_TYPE_LOAD_REQ, `MSG_TYPE_LOAD_MEM_ACK, 8'h07, 8'h41);

        // slverr once per direction on a5
        store_word(`MSG_TYPE_STORE_REQ, `MSG_TYPE_STORE_MEM_ACK, 8'h08, 8'ha5,
                   32'h1234_abcd, 8'd3);
        load_word(`MSG_TYPE_NC_LOAD_REQ, `MSG_TYPE_NC_LOAD_MEM_ACK, 8'h09, 8'ha5);

        // back to back mix, two in flight under stalls
        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            d = $random(seed);
            if (r[8]) begin
                if (r[9]) store_word(`MSG_TYPE_STORE_REQ, `MSG_TYPE_STORE_MEM_ACK,
                                     8'h20 + i[7:0], r[7:0], d, 8'd3);
                else      store_word(`MSG_TYPE_NC_STORE_REQ, `MSG_TYPE_NC_STORE_MEM_ACK,
                                     8'h20 + i[7:0], r[7:0], d, 8'd3);
            end else begin
                if (r[9]) load_word(`MSG_TYPE_LOAD_MEM, `MSG_TYPE_LOAD_MEM_ACK,
                                    8'h20 + i[7:0], r[7:0]);
                else      load_word(`MSG_TYPE_NC_LOAD_REQ, `MSG_TYPE_NC_LOAD_MEM_ACK,
                                    8'h20 + i[7:0], r[7:0]);
            end
        end

        while (exp_q.size() != 0) @(negedge clk);
        // quiet tail, catches stray flits
        repeat (20) @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule
